/* verilog/motion_pkg.sv */
package motion_pkg;

    // screen coordinates, y grows downward
    typedef logic [9:0] pos_x_t;
    typedef logic [8:0] pos_y_t;

    // received keyboard scan code
    typedef logic [7:0] scan_code_t;

    // physics counters and timer values
    typedef logic [9:0] timer_t;

    // scan codes of the keys the engine reacts to
    // jump
    localparam scan_code_t KEY_W = 8'h1D;
    // walk left
    localparam scan_code_t KEY_A = 8'h1C;
    // walk right
    localparam scan_code_t KEY_D = 8'h23;
    // back to spawn
    localparam scan_code_t KEY_R = 8'h2D;

    // clocks per game tick
    localparam timer_t TICK_DIV = 10'd8;

    // horizontal counter limit, one pixel every MOVE_PERIOD + 1 ticks
    localparam timer_t MOVE_PERIOD = 10'd75;

    // jump timer, slows down while rising
    localparam timer_t JUMP_START = 10'd25;
    localparam timer_t JUMP_END = 10'd50;

    // fall timer, speeds up while falling
    localparam timer_t FALL_START = 10'd50;
    localparam timer_t FALL_MIN = 10'd20;

    // pixels between speed changes
    localparam timer_t SPEED_STEPS = 10'd24;

    // timer change per speed change
    localparam timer_t SPEED_DELTA = 10'd5;

    // restart position
    localparam pos_x_t SPAWN_X = 10'd0;
    localparam pos_y_t SPAWN_Y = 9'd357;

endpackage

/* verilog/key_if.sv */
`timescale 1ns/1ps

interface key_if;

    // keys currently held down
    logic held_w;
    logic held_a;
    logic held_d;

    // single cycle pulse on the restart make code
    logic restart;

    modport source (
        output held_w,
        output held_a,
        output held_d,
        output restart
    );

    modport sink (
        input held_w,
        input held_a,
        input held_d,
        input restart
    );

endinterface

/* verilog/step_if.sv */
`timescale 1ns/1ps

interface step_if;

    // one pixel step pulses
    logic step_left;
    logic step_right;
    logic step_up;
    logic step_down;

    // player flags
    logic facing_right;
    logic airborne;
    logic moving;

    // restart forwarded from the key decoder
    logic restart;

    modport source (
        output step_left, step_right, step_up, step_down,
        output facing_right, airborne, moving,
        output restart
    );

    modport sink (
        input step_left, step_right, step_up, step_down,
        input facing_right, airborne, moving,
        input restart
    );

endinterface

/* verilog/key_decode.sv */
`timescale 1ns/1ps

module key_decode (
    input  logic                   clk,
    input  logic                   rst_i,
    input  logic                   key_req_i,
    input  motion_pkg::scan_code_t key_code_i,
    input  logic                   key_break_i,
    output logic                   key_ack_o,
    key_if.source                  keys_o
);

    logic ack_q;
    logic accept;
    logic held_w_q;
    logic held_a_q;
    logic held_d_q;
    logic restart_q;

    // new event: req high while ack still low
    assign accept = key_req_i && !ack_q;

    // four-phase handshake
    always_ff @(posedge clk) begin
        if (rst_i) begin
            ack_q <= 1'b0;
        end else if (accept) begin
            ack_q <= 1'b1;
        end else if (!key_req_i) begin
            // sender has released req
            ack_q <= 1'b0;
        end
    end

    // held keys follow make and break codes of the same key
    always_ff @(posedge clk) begin
        restart_q <= 1'b0;
        if (rst_i) begin
            held_w_q <= 1'b0;
            held_a_q <= 1'b0;
            held_d_q <= 1'b0;
        end else if (accept) begin
            case (key_code_i)
                motion_pkg::KEY_W: begin
                    held_w_q <= !key_break_i;
                end
                motion_pkg::KEY_A: begin
                    held_a_q <= !key_break_i;
                end
                motion_pkg::KEY_D: begin
                    held_d_q <= !key_break_i;
                end
                motion_pkg::KEY_R: begin
                    // only the make code restarts
                    restart_q <= !key_break_i;
                end
                default: begin
                end
            endcase
        end
    end

    assign key_ack_o = ack_q;

    assign keys_o.held_w = held_w_q;
    assign keys_o.held_a = held_a_q;
    assign keys_o.held_d = held_d_q;
    assign keys_o.restart = restart_q;

endmodule

/* verilog/motion_execute.sv */
`timescale 1ns/1ps

module motion_execute (
    input  logic  clk,
    input  logic  rst_i,
    key_if.sink   keys_i,
    input  logic  coll_down_i,
    input  logic  coll_up_i,
    input  logic  coll_right_i,
    input  logic  coll_left_i,
    step_if.source steps_o
);

    motion_pkg::timer_t tick_cnt;
    motion_pkg::timer_t left_cnt;
    motion_pkg::timer_t right_cnt;
    motion_pkg::timer_t up_cnt;
    motion_pkg::timer_t down_cnt;
    motion_pkg::timer_t jump_timer;
    motion_pkg::timer_t fall_timer;
    motion_pkg::timer_t jump_steps;
    motion_pkg::timer_t fall_steps;

    logic tick;
    logic jumping;
    logic jump_now;
    logic step_left_q;
    logic step_right_q;
    logic step_up_q;
    logic step_down_q;
    logic facing_q;
    logic airborne_q;
    logic moving_q;

    // game tick, one cycle in every TICK_DIV
    assign tick = (tick_cnt == motion_pkg::TICK_DIV - 1'b1);

    always_ff @(posedge clk) begin
        if (rst_i || keys_i.restart || tick) begin
            tick_cnt <= '0;
        end else begin
            tick_cnt <= tick_cnt + 1'b1;
        end
    end

    // horizontal walk, left wins only when right is not held
    always_ff @(posedge clk) begin
        step_left_q <= 1'b0;
        step_right_q <= 1'b0;
        if (rst_i) begin
            left_cnt <= '0;
            right_cnt <= '0;
            facing_q <= 1'b0;
            moving_q <= 1'b0;
        end else if (keys_i.restart) begin
            left_cnt <= '0;
            right_cnt <= '0;
        end else if (tick) begin
            if (keys_i.held_a && !keys_i.held_d && !coll_left_i) begin
                facing_q <= 1'b0;
                moving_q <= 1'b1;
                if (left_cnt < motion_pkg::MOVE_PERIOD) begin
                    left_cnt <= left_cnt + 1'b1;
                end else begin
                    left_cnt <= '0;
                    step_left_q <= 1'b1;
                end
            end else if (keys_i.held_d && !coll_right_i) begin
                facing_q <= 1'b1;
                moving_q <= 1'b1;
                if (right_cnt < motion_pkg::MOVE_PERIOD) begin
                    right_cnt <= right_cnt + 1'b1;
                end else begin
                    right_cnt <= '0;
                    step_right_q <= 1'b1;
                end
            end else begin
                moving_q <= 1'b0;
            end
        end
    end

    // jump state for this tick, end of rise checked before a new start
    always_comb begin
        jump_now = jumping;
        if (coll_up_i || jump_timer >= motion_pkg::JUMP_END) begin
            jump_now = 1'b0;
        end else if (keys_i.held_w && coll_down_i) begin
            jump_now = 1'b1;
        end
    end

    // vertical motion
    always_ff @(posedge clk) begin
        step_up_q <= 1'b0;
        step_down_q <= 1'b0;
        if (rst_i || keys_i.restart) begin
            jumping <= 1'b0;
            up_cnt <= '0;
            down_cnt <= '0;
            jump_timer <= motion_pkg::JUMP_START;
            fall_timer <= motion_pkg::FALL_START;
            jump_steps <= '0;
            fall_steps <= '0;
            if (rst_i) begin
                airborne_q <= 1'b0;
            end
        end else if (tick) begin
            jumping <= jump_now;
            airborne_q <= !coll_down_i;
            if (jump_now) begin
                // rising, slower every SPEED_STEPS pixels
                fall_timer <= motion_pkg::FALL_START;
                fall_steps <= '0;
                if (jump_steps == motion_pkg::SPEED_STEPS) begin
                    jump_timer <= jump_timer + motion_pkg::SPEED_DELTA;
                    jump_steps <= '0;
                end else if (up_cnt < jump_timer) begin
                    up_cnt <= up_cnt + 1'b1;
                end else begin
                    up_cnt <= '0;
                    step_up_q <= 1'b1;
                    jump_steps <= jump_steps + 1'b1;
                end
            end else begin
                jump_timer <= motion_pkg::JUMP_START;
                jump_steps <= '0;
                up_cnt <= '0;
                if (!coll_down_i) begin
                    // falling, faster every SPEED_STEPS pixels
                    if (fall_steps == motion_pkg::SPEED_STEPS) begin
                        if (fall_timer > motion_pkg::FALL_MIN + motion_pkg::SPEED_DELTA) begin
                            fall_timer <= fall_timer - motion_pkg::SPEED_DELTA;
                        end else begin
                            fall_timer <= motion_pkg::FALL_MIN;
                        end
                        fall_steps <= '0;
                    end else if (down_cnt < fall_timer) begin
                        down_cnt <= down_cnt + 1'b1;
                    end else begin
                        down_cnt <= '0;
                        step_down_q <= 1'b1;
                        fall_steps <= fall_steps + 1'b1;
                    end
                end else begin
                    // landed
                    fall_timer <= motion_pkg::FALL_START;
                    fall_steps <= '0;
                    down_cnt <= '0;
                end
            end
        end
    end

    assign steps_o.step_left = step_left_q;
    assign steps_o.step_right = step_right_q;
    assign steps_o.step_up = step_up_q;
    assign steps_o.step_down = step_down_q;
    assign steps_o.facing_right = facing_q;
    assign steps_o.airborne = airborne_q;
    assign steps_o.moving = moving_q;
    assign steps_o.restart = keys_i.restart;

endmodule

/* verilog/position_result.sv */
`timescale 1ns/1ps

module position_result (
    input  logic               clk,
    input  logic               rst_i,
    step_if.sink               steps_i,
    output motion_pkg::pos_x_t pos_x_o,
    output motion_pkg::pos_y_t pos_y_o,
    output logic               facing_right_o,
    output logic               airborne_o,
    output logic               moving_o
);

    motion_pkg::pos_x_t pos_x_q;
    motion_pkg::pos_y_t pos_y_q;

    // one pixel per step, held at the screen edges
    always_ff @(posedge clk) begin
        if (rst_i || steps_i.restart) begin
            pos_x_q <= motion_pkg::SPAWN_X;
            pos_y_q <= motion_pkg::SPAWN_Y;
        end else begin
            if (steps_i.step_left && pos_x_q != '0) begin
                pos_x_q <= pos_x_q - 1'b1;
            end else if (steps_i.step_right && pos_x_q != '1) begin
                pos_x_q <= pos_x_q + 1'b1;
            end
            // up is toward row zero
            if (steps_i.step_up && pos_y_q != '0) begin
                pos_y_q <= pos_y_q - 1'b1;
            end else if (steps_i.step_down && pos_y_q != '1) begin
                pos_y_q <= pos_y_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            facing_right_o <= 1'b0;
            airborne_o <= 1'b0;
            moving_o <= 1'b0;
        end else begin
            facing_right_o <= steps_i.facing_right;
            airborne_o <= steps_i.airborne;
            moving_o <= steps_i.moving;
        end
    end

    assign pos_x_o = pos_x_q;
    assign pos_y_o = pos_y_q;

endmodule

/* verilog/motion_core.sv */
`timescale 1ns/1ps

module motion_core (
    input  logic                   clk,
    input  logic                   rst_i,

    // key events, four-phase req/ack
    input  logic                   key_req_i,
    input  motion_pkg::scan_code_t key_code_i,
    input  logic                   key_break_i,
    output logic                   key_ack_o,

    // collisions from the map engine
    input  logic                   coll_down_i,
    input  logic                   coll_up_i,
    input  logic                   coll_right_i,
    input  logic                   coll_left_i,

    // player state
    output motion_pkg::pos_x_t     pos_x_o,
    output motion_pkg::pos_y_t     pos_y_o,
    output logic                   facing_right_o,
    output logic                   airborne_o,
    output logic                   moving_o
);

    key_if  u_key_if ();
    step_if u_step_if ();

    key_decode u_key_decode (
        .clk         (clk),
        .rst_i       (rst_i),
        .key_req_i   (key_req_i),
        .key_code_i  (key_code_i),
        .key_break_i (key_break_i),
        .key_ack_o   (key_ack_o),
        .keys_o      (u_key_if.source)
    );

    motion_execute u_motion_execute (
        .clk          (clk),
        .rst_i        (rst_i),
        .keys_i       (u_key_if.sink),
        .coll_down_i  (coll_down_i),
        .coll_up_i    (coll_up_i),
        .coll_right_i (coll_right_i),
        .coll_left_i  (coll_left_i),
        .steps_o      (u_step_if.source)
    );

    position_result u_position_result (
        .clk            (clk),
        .rst_i          (rst_i),
        .steps_i        (u_step_if.sink),
        .pos_x_o        (pos_x_o),
        .pos_y_o        (pos_y_o),
        .facing_right_o (facing_right_o),
        .airborne_o     (airborne_o),
        .moving_o       (moving_o)
    );

endmodule

/* tb/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk,
    output logic rst_o
);

    localparam real HALF_PERIOD = 4.0;
    localparam int RESET_CYCLES = 10;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // reset drops 1 ns after the last reset edge
    initial begin
        rst_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_o = 1'b0;
    end

endmodule

/* tb/tb_motion_core.sv */
`timescale 1ns/1ps

module tb_motion_core;

    // expected change of a coordinate value over one row
    localparam logic [1:0] DIR_NONE = 2'd0;
    localparam logic [1:0] DIR_INC = 2'd1;
    localparam logic [1:0] DIR_DEC = 2'd2;

    localparam int NUM_ROWS = 13;
    localparam int HOLD_CYCLES = 1000;
    localparam int STEP_TIMEOUT = 800;
    localparam int ACK_TIMEOUT = 20;
    localparam int RESET_TIMEOUT = 50;
    localparam int MAX_GAP = 16;

    logic clk;
    logic rst_i;
    logic key_req_i;
    motion_pkg::scan_code_t key_code_i;
    logic key_break_i;
    logic key_ack_o;
    logic coll_down_i;
    logic coll_up_i;
    logic coll_right_i;
    logic coll_left_i;
    motion_pkg::pos_x_t pos_x_o;
    motion_pkg::pos_y_t pos_y_o;
    logic facing_right_o;
    logic airborne_o;
    logic moving_o;

    // stimulus table, one entry per row
    logic                   row_has_key [NUM_ROWS];
    motion_pkg::scan_code_t row_code    [NUM_ROWS];
    logic                   row_break   [NUM_ROWS];
    // down, up, right, left
    logic [3:0]             row_coll    [NUM_ROWS];
    logic [1:0]             row_dx      [NUM_ROWS];
    logic [1:0]             row_dy      [NUM_ROWS];
    motion_pkg::pos_y_t     row_steps   [NUM_ROWS];
    logic                   row_spawn   [NUM_ROWS];
    // facing_right, airborne, moving
    logic [2:0]             row_flags   [NUM_ROWS];
    int                     row_count;

    // expected position, kept from the row rules
    motion_pkg::pos_x_t exp_x;
    motion_pkg::pos_y_t exp_y;

    int unsigned seed;
    int idx;

    tb_clk_gen u_tb_clk_gen (
        .clk   (clk),
        .rst_o (rst_i)
    );

    motion_core u_motion_core (
        .clk            (clk),
        .rst_i          (rst_i),
        .key_req_i      (key_req_i),
        .key_code_i     (key_code_i),
        .key_break_i    (key_break_i),
        .key_ack_o      (key_ack_o),
        .coll_down_i    (coll_down_i),
        .coll_up_i      (coll_up_i),
        .coll_right_i   (coll_right_i),
        .coll_left_i    (coll_left_i),
        .pos_x_o        (pos_x_o),
        .pos_y_o        (pos_y_o),
        .facing_right_o (facing_right_o),
        .airborne_o     (airborne_o),
        .moving_o       (moving_o)
    );

    task automatic fail_run();
        begin
            $display("Some tests failed");
            $fatal(1);
        end
    endtask

    task automatic report_error(input string what);
        begin
            $display("ERR %0t: %s", $time, what);
            fail_run();
        end
    endtask

    task automatic report_timeout(input string what);
        begin
            $display("Timed out at %0t while waiting for %s", $time, what);
            fail_run();
        end
    endtask

    // all driving and sampling happens 1 ns after the rising edge
    task automatic next_cycle();
        begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic check_pos(input motion_pkg::pos_x_t ex, input motion_pkg::pos_y_t ey);
        begin
            if (pos_x_o !== ex || pos_y_o !== ey) begin
                report_error($sformatf("position x=%0d y=%0d, expected x=%0d y=%0d",
                                       pos_x_o, pos_y_o, ex, ey));
            end
        end
    endtask

    task automatic check_flags(input logic ef, input logic ea, input logic em);
        begin
            if (facing_right_o !== ef || airborne_o !== ea || moving_o !== em) begin
                report_error($sformatf("flags f=%b a=%b m=%b, expected f=%b a=%b m=%b",
                                       facing_right_o, airborne_o, moving_o, ef, ea, em));
            end
        end
    endtask

    task automatic check_ack(input logic ea);
        begin
            if (key_ack_o !== ea) begin
                report_error($sformatf("key ack is %b, expected %b", key_ack_o, ea));
            end
        end
    endtask

    task automatic add_row(input logic has_key, input motion_pkg::scan_code_t code,
                           input logic brk, input logic [3:0] coll, input logic [1:0] dx,
                           input logic [1:0] dy, input motion_pkg::pos_y_t steps,
                           input logic to_spawn, input logic [2:0] flags);
        begin
            row_has_key[row_count] = has_key;
            row_code[row_count] = code;
            row_break[row_count] = brk;
            row_coll[row_count] = coll;
            row_dx[row_count] = dx;
            row_dy[row_count] = dy;
            row_steps[row_count] = steps;
            row_spawn[row_count] = to_spawn;
            row_flags[row_count] = flags;
            row_count = row_count + 1;
        end
    endtask

    task automatic load_table();
        begin
            row_count = 0;
            add_row(1'b0, 8'h00, 1'b0, 4'b1000, DIR_NONE, DIR_NONE, 9'd0, 1'b0, 3'b000);
            // walk right, then blocked, then released
            add_row(1'b1, motion_pkg::KEY_D, 1'b0, 4'b1000, DIR_INC, DIR_NONE, 9'd3, 1'b0, 3'b101);
            add_row(1'b0, 8'h00, 1'b0, 4'b1010, DIR_NONE, DIR_NONE, 9'd0, 1'b0, 3'b100);
            add_row(1'b1, motion_pkg::KEY_D, 1'b1, 4'b1000, DIR_NONE, DIR_NONE, 9'd0, 1'b0, 3'b100);
            // walk left, then blocked, then released
            add_row(1'b1, motion_pkg::KEY_A, 1'b0, 4'b1000, DIR_DEC, DIR_NONE, 9'd1, 1'b0, 3'b001);
            add_row(1'b0, 8'h00, 1'b0, 4'b1001, DIR_NONE, DIR_NONE, 9'd0, 1'b0, 3'b000);
            add_row(1'b1, motion_pkg::KEY_A, 1'b1, 4'b1000, DIR_NONE, DIR_NONE, 9'd0, 1'b0, 3'b000);
            // fall, land, restart
            add_row(1'b0, 8'h00, 1'b0, 4'b0000, DIR_NONE, DIR_INC, 9'd2, 1'b0, 3'b010);
            add_row(1'b0, 8'h00, 1'b0, 4'b1000, DIR_NONE, DIR_NONE, 9'd0, 1'b0, 3'b000);
            add_row(1'b1, motion_pkg::KEY_R, 1'b0, 4'b1000, DIR_NONE, DIR_NONE, 9'd0, 1'b1, 3'b000);
            // jump, hit the ceiling, fall back
            add_row(1'b1, motion_pkg::KEY_W, 1'b0, 4'b1000, DIR_NONE, DIR_DEC, 9'd2, 1'b0, 3'b000);
            add_row(1'b0, 8'h00, 1'b0, 4'b0100, DIR_NONE, DIR_INC, 9'd2, 1'b0, 3'b010);
            add_row(1'b1, motion_pkg::KEY_W, 1'b1, 4'b1000, DIR_NONE, DIR_NONE, 9'd0, 1'b0, 3'b000);
        end
    endtask

    task automatic send_key(input motion_pkg::scan_code_t code, input logic brk);
        int n;
        begin
            check_ack(1'b0);
            key_code_i = code;
            key_break_i = brk;
            key_req_i = 1'b1;
            n = 0;
            while (key_ack_o !== 1'b1) begin
                if (n >= ACK_TIMEOUT) begin
                    report_timeout("key ack to rise");
                end
                next_cycle();
                n = n + 1;
            end
            // ack has to stay up while req is still held
            next_cycle();
            check_ack(1'b1);
            key_req_i = 1'b0;
            n = 0;
            while (key_ack_o !== 1'b0) begin
                if (n >= ACK_TIMEOUT) begin
                    report_timeout("key ack to fall");
                end
                next_cycle();
                n = n + 1;
            end
        end
    endtask

    task automatic wait_for_pos(input motion_pkg::pos_x_t tx, input motion_pkg::pos_y_t ty,
                                input int max_cycles, input string what);
        int n;
        begin
            n = 0;
            while (pos_x_o !== tx || pos_y_o !== ty) begin
                if (n >= max_cycles) begin
                    report_timeout(what);
                end
                next_cycle();
                n = n + 1;
            end
            check_pos(tx, ty);
        end
    endtask

    task automatic run_row(input int r);
        int gap;
        motion_pkg::pos_x_t tgt_x;
        motion_pkg::pos_y_t tgt_y;
        begin
            gap = $urandom % MAX_GAP;
            repeat (gap) next_cycle();
            check_pos(exp_x, exp_y);
            if (row_has_key[r]) begin
                send_key(row_code[r], row_break[r]);
            end
            {coll_down_i, coll_up_i, coll_right_i, coll_left_i} = row_coll[r];
            if (row_spawn[r]) begin
                exp_x = motion_pkg::SPAWN_X;
                exp_y = motion_pkg::SPAWN_Y;
                wait_for_pos(exp_x, exp_y, 10, "the return to the spawn point");
            end
            tgt_x = exp_x;
            tgt_y = exp_y;
            if (row_dx[r] == DIR_INC) tgt_x = exp_x + row_steps[r];
            if (row_dx[r] == DIR_DEC) tgt_x = exp_x - row_steps[r];
            if (row_dy[r] == DIR_INC) tgt_y = exp_y + row_steps[r];
            if (row_dy[r] == DIR_DEC) tgt_y = exp_y - row_steps[r];
            if (row_dx[r] != DIR_NONE || row_dy[r] != DIR_NONE) begin
                wait_for_pos(tgt_x, tgt_y, row_steps[r] * STEP_TIMEOUT + 200,
                             $sformatf("the position steps of row %0d", r));
                exp_x = tgt_x;
                exp_y = tgt_y;
            end else begin
                // position must not move over the whole window
                repeat (HOLD_CYCLES) begin
                    next_cycle();
                    check_pos(exp_x, exp_y);
                end
            end
            check_flags(row_flags[r][2], row_flags[r][1], row_flags[r][0]);
        end
    endtask

    initial begin
        int n;
        key_req_i = 1'b0;
        key_code_i = '0;
        key_break_i = 1'b0;
        coll_down_i = 1'b1;
        coll_up_i = 1'b0;
        coll_right_i = 1'b0;
        coll_left_i = 1'b0;
        seed = 32'h63f9;
        seed = $urandom(seed);
        load_table();

        // rst_i only changes 1 ns after an edge, so the edge value is stable
        n = 0;
        @(posedge clk);
        while (rst_i !== 1'b0) begin
            if (n >= RESET_TIMEOUT) begin
                report_timeout("the reset to be released");
            end
            @(posedge clk);
            n = n + 1;
        end
        #1;

        check_pos(motion_pkg::SPAWN_X, motion_pkg::SPAWN_Y);
        check_flags(1'b0, 1'b0, 1'b0);
        check_ack(1'b0);
        exp_x = motion_pkg::SPAWN_X;
        exp_y = motion_pkg::SPAWN_Y;

        for (idx = 0; idx < row_count; idx = idx + 1) begin
            run_row(idx);
        end

        $display("All tests passed");
        $finish;
    end

endmodule

/* tb.f */
verilog/motion_pkg.sv
verilog/key_if.sv
verilog/step_if.sv
verilog/key_decode.sv
verilog/motion_execute.sv
verilog/position_result.sv
verilog/motion_core.sv
tb/tb_clk_gen.sv
tb/tb_motion_core.sv

/* Bender.yml */
package:
  name: motion_core

sources:
  # package first, then interfaces, then the stages and the top level
  - verilog/motion_pkg.sv
  - verilog/key_if.sv
  - verilog/step_if.sv
  - verilog/key_decode.sv
  - verilog/motion_execute.sv
  - verilog/position_result.sv
  - verilog/motion_core.sv

  - target: test
    files:
      - tb/tb_clk_gen.sv
      - tb/tb_motion_core.sv
